// ==== sources.f ====
verilog/spi_pkg.sv
verilog/spi_bus_regs.sv
verilog/spi_sequencer.sv
verilog/spi_shifter.sv
verilog/spi_master.sv
testbench/spi_master_properties.sv
testbench/spi_master_tb.sv

// ==== testbench/spi_master_properties.sv ====
// --------------------------------------------------
// bus and select-line rules, bound into spi_master
// --------------------------------------------------
module spi_master_properties (
   input logic         CLK_I,
   input logic         RST_I,
   input logic         ack,
   input logic         sclk,
   input logic         sso,
   input spi_pkg::ss_t ss_n
);
   timeunit 1ns;
   timeprecision 1ns;

   int assert_failures = 0;   // read by the testbench at the end

   // ack is a single-cycle pulse
   a_ack_pulse: assert property (@(posedge CLK_I) disable iff (RST_I) ack |=> !ack)
      else begin
         assert_failures = assert_failures + 1;
         $error("ack high for two cycles in a row");
      end

   a_sclk_idle: assert property (@(posedge CLK_I) disable iff (RST_I)
                                 ((&ss_n) && !sso) |-> !sclk)
      else begin
         assert_failures = assert_failures + 1;
         $error("sclk high with no slave selected");
      end

   // select lines do not move on an sclk edge
   a_ss_stable: assert property (@(posedge CLK_I) disable iff (RST_I)
                                 (sclk != $past(sclk)) |-> $stable(ss_n))
      else begin
         assert_failures = assert_failures + 1;
         $error("ss_n changed while sclk toggled");
      end

endmodule

bind spi_master spi_master_properties i_spi_master_properties (
   .CLK_I (CLK_I),
   .RST_I (RST_I),
   .ack   (ack),
   .sclk  (sclk),
   .sso   (sso),
   .ss_n  (ss_n)
);

// ==== testbench/spi_master_tb.sv ====
// --------------------------------------------------
// random frames checked against a register/flag model
// ss_mask kept nonzero whenever a frame runs
// --------------------------------------------------
module spi_master_tb;
   timeunit 1ns;
   timeprecision 1ns;

   import spi_pkg::*;

   localparam int    CLK_PERIOD     = 40;
   localparam int    NUM_FRAMES     = 20;
   localparam int    FRAME_CYCLES   = 120;
   localparam int    TIMEOUT_CYCLES = 40 * FRAME_CYCLES + 1000;
   localparam data_t SSO_BIT        = data_t'(1 << CTRL_SSO);
   localparam data_t CTRL_USED      = data_t'((1 << CTRL_IROE) | (1 << CTRL_ITOE) |
                                              (1 << CTRL_ITRDY) | (1 << CTRL_IRRDY) |
                                              (1 << CTRL_IE) | (1 << CTRL_SSO));

   logic  CLK_I;
   logic  RST_I;
   addr_t adr;
   data_t dat_w;
   logic  we;
   logic  cyc;
   logic  stb;
   data_t dat_r;
   logic  ack;
   logic  irq;
   logic  sclk;
   logic  mosi;
   logic  miso;
   ss_t   ss_n;

   // model of registers and flags
   data_t       m_ctrl;
   ss_t         m_mask;
   data_t       m_rx;
   logic        m_trdy;
   logic        m_toe;
   logic        m_rrdy;
   logic        m_roe;
   logic [31:0] rng;
   int          cycle_count;
   data_t       cap_q[$];     // bytes seen on mosi
   data_t       reply_q[$];   // bytes sent on miso

   spi_master i_spi_master (
      .CLK_I (CLK_I),
      .RST_I (RST_I),
      .adr   (adr),
      .dat_w (dat_w),
      .we    (we),
      .cyc   (cyc),
      .stb   (stb),
      .dat_r (dat_r),
      .ack   (ack),
      .irq   (irq),
      .sclk  (sclk),
      .mosi  (mosi),
      .miso  (miso),
      .ss_n  (ss_n)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic data_t rand_byte();
      rng = xorshift32(rng);
      return rng[15:8];
   endfunction

   function automatic data_t model_status();
      data_t s;
      s            = '0;
      s[STAT_ERR]  = m_toe | m_roe;
      s[STAT_RRDY] = m_rrdy;
      s[STAT_TRDY] = m_trdy;
      s[STAT_TMT]  = 1'b1;   // only read between frames
      s[STAT_TOE]  = m_toe;
      s[STAT_ROE]  = m_roe;
      return s;
   endfunction

   function automatic logic model_irq();
      logic err_irq;
      err_irq = (m_ctrl[CTRL_IROE] & m_roe) | (m_ctrl[CTRL_ITOE] & m_toe);
      return (m_ctrl[CTRL_IE] & err_irq) | (m_ctrl[CTRL_ITRDY] & m_trdy) |
             (m_ctrl[CTRL_IRRDY] & m_rrdy);
   endfunction

   function automatic data_t model_read(input reg_addr_e a);
      case (a)
         RX_DATA: return m_rx;
         STATUS:  return model_status();
         CONTROL: return m_ctrl;
         SS_MASK: return data_t'(m_mask);
         default: return '0;
      endcase
   endfunction

   task automatic stop_run();
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_data(input data_t got, input data_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_ss(input ss_t got, input ss_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
         stop_run();
      end
   endtask

   // --------------------------------------------------
   // bus access, stb held until ack
   // --------------------------------------------------
   task automatic bus_write(input reg_addr_e a, input data_t d);
      @(negedge CLK_I);
      adr   = a;
      dat_w = d;
      we    = 1'b1;
      cyc   = 1'b1;
      stb   = 1'b1;
      do @(negedge CLK_I); while (ack !== 1'b1);
      stb = 1'b0;
      cyc = 1'b0;
      we  = 1'b0;
   endtask

   task automatic bus_read(input reg_addr_e a, output data_t d);
      @(negedge CLK_I);
      adr = a;
      we  = 1'b0;
      cyc = 1'b1;
      stb = 1'b1;
      do @(negedge CLK_I); while (ack !== 1'b1);
      d   = dat_r;   // valid with ack
      stb = 1'b0;
      cyc = 1'b0;
   endtask

   task automatic write_reg(input reg_addr_e a, input data_t d);
      bus_write(a, d);
      case (a)
         TX_DATA: begin
            if (!m_trdy)
               m_toe = 1'b1;
            m_trdy = 1'b0;
         end
         STATUS:  m_toe = 1'b0;
         CONTROL: m_ctrl = d & CTRL_USED;
         SS_MASK: m_mask = d[SLAVE_NUMBER-1:0];
         default: ;
      endcase
      @(negedge CLK_I);   // update lands on the edge after ack
      check_bit(irq, model_irq(), "irq after write");
   endtask

   task automatic read_check(input reg_addr_e a, input string what);
      data_t got;
      data_t exp;
      exp = model_read(a);
      bus_read(a, got);
      check_data(got, exp, what);
      if (a == RX_DATA) begin
         m_rrdy = 1'b0;
         m_roe  = 1'b0;
      end
      @(negedge CLK_I);
      check_bit(irq, model_irq(), "irq after read");
   endtask

   // poll until tmt, flags move under the model here
   task automatic wait_tmt();
      data_t s;
      do begin
         bus_read(STATUS, s);
      end while (!s[STAT_TMT]);
   endtask

   task automatic finish_frames(input int n, input data_t tx);
      data_t cap;
      data_t reply;
      if (cap_q.size() != n) begin
         $display("slave model saw %0d frames where %0d were expected", cap_q.size(), n);
         stop_run();
      end else begin
         repeat (n) begin
            cap   = cap_q.pop_front();
            reply = reply_q.pop_front();
            check_data(cap, tx, "byte seen by slave");
            m_trdy = 1'b1;
            if (m_rrdy) begin
               m_roe = 1'b1;
            end else begin
               m_rrdy = 1'b1;
               m_rx   = reply;
            end
         end
      end
   endtask

   // --------------------------------------------------
   // clock, timeout, slave model
   // --------------------------------------------------
   initial begin
      CLK_I = 1'b0;
      forever #(CLK_PERIOD / 2) CLK_I = ~CLK_I;
   end

   initial begin
      cycle_count = 0;
      forever begin
         @(posedge CLK_I);
         cycle_count++;
         if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
         end else if (i_spi_master.i_spi_master_properties.assert_failures != 0) begin
            $display("a concurrent assertion failed during the run");
            stop_run();
         end
      end
   end

   // mode 0 slave, watched on the falling clk edge
   initial begin
      logic [31:0] slave_rng;
      data_t       cur_reply;
      data_t       cap_byte;
      int          tx_bit;
      int          rise_cnt;
      logic        sclk_q;
      logic        sel_q;
      slave_rng = ~32'd74640;
      cur_reply = '0;
      cap_byte  = '0;
      tx_bit    = -1;
      rise_cnt  = 0;
      sclk_q    = 1'b0;
      sel_q     = 1'b0;
      miso      = 1'b0;
      forever begin
         @(negedge CLK_I);
         if (!RST_I) begin
            if (!sel_q && !(&ss_n)) begin   // select fell, first bit out
               slave_rng = xorshift32(slave_rng);
               cur_reply = slave_rng[7:0];
               miso      = cur_reply[DATA_LENGTH-1];
               tx_bit    = DATA_LENGTH - 2;
               rise_cnt  = 0;
            end
            if (sclk && !sclk_q) begin
               check_ss(ss_n, ~m_mask, "ss_n at sclk rise");
               cap_byte = {cap_byte[DATA_LENGTH-2:0], mosi};
               rise_cnt++;
               if (rise_cnt == DATA_LENGTH) begin
                  cap_q.push_back(cap_byte);
                  reply_q.push_back(cur_reply);
               end
            end
            if (!sclk && sclk_q) begin
               check_ss(ss_n, ~m_mask, "ss_n at sclk fall");
               if (tx_bit >= 0) begin
                  miso = cur_reply[tx_bit];
                  tx_bit--;
               end
            end
            sclk_q = sclk;
            sel_q  = !(&ss_n);
         end
      end
   end

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      data_t tx;
      data_t tx_b;
      data_t v;
      ss_t   mask;
      rng    = 32'd74640;
      m_ctrl = '0;
      m_mask = '0;
      m_rx   = '0;
      m_trdy = 1'b1;
      m_toe  = 1'b0;
      m_rrdy = 1'b0;
      m_roe  = 1'b0;
      RST_I  = 1'b1;
      adr    = '0;
      dat_w  = '0;
      we     = 1'b0;
      cyc    = 1'b0;
      stb    = 1'b0;
      repeat (5) @(posedge CLK_I);
      @(negedge CLK_I);
      RST_I = 1'b0;

      // reset values
      check_ss(ss_n, '1, "ss_n after reset");
      check_bit(sclk, 1'b0, "sclk after reset");
      check_bit(irq, 1'b0, "irq after reset");
      read_check(STATUS, "status after reset");
      read_check(CONTROL, "control after reset");
      read_check(SS_MASK, "ss_mask after reset");
      read_check(RX_DATA, "rx data after reset");

      // register readback
      repeat (12) begin
         write_reg(CONTROL, rand_byte());
         read_check(CONTROL, "control readback");
         write_reg(SS_MASK, rand_byte());
         read_check(SS_MASK, "ss_mask readback");
      end

      // single frames
      write_reg(CONTROL, rand_byte() & ~SSO_BIT);
      for (int i = 0; i < NUM_FRAMES; i++) begin
         v    = rand_byte();
         mask = (v[SLAVE_NUMBER-1:0] == '0) ? ss_t'(1) : v[SLAVE_NUMBER-1:0];
         write_reg(SS_MASK, data_t'(mask));
         tx = rand_byte();
         write_reg(TX_DATA, tx);
         wait_tmt();
         finish_frames(1, tx);
         read_check(STATUS, "status after frame");
         read_check(RX_DATA, "rx data after frame");
         read_check(STATUS, "status after rx read");
      end

      // back to back writes, second byte replaces the first
      tx   = rand_byte();
      tx_b = rand_byte();
      write_reg(TX_DATA, tx);
      write_reg(TX_DATA, tx_b);
      wait_tmt();
      finish_frames(2, tx_b);
      read_check(STATUS, "status after overrun");
      write_reg(STATUS, 8'h00);
      read_check(STATUS, "status after toe clear");
      read_check(RX_DATA, "rx data kept on overrun");
      read_check(STATUS, "status after roe clear");

      // forced select, no frame
      v    = rand_byte();
      mask = (v[SLAVE_NUMBER-1:0] == '0) ? ss_t'(1) : v[SLAVE_NUMBER-1:0];
      write_reg(SS_MASK, data_t'(mask));
      write_reg(CONTROL, m_ctrl | SSO_BIT);
      repeat (20) begin
         @(negedge CLK_I);
         check_ss(ss_n, ~m_mask, "ss_n with sso");
         check_bit(sclk, 1'b0, "sclk with sso");
      end
      write_reg(CONTROL, m_ctrl & ~SSO_BIT);
      @(negedge CLK_I);
      check_ss(ss_n, '1, "ss_n after sso cleared");

      if (i_spi_master.i_spi_master_properties.assert_failures == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         $display("a concurrent assertion failed during the run");
         stop_run();
      end
   end

endmodule

// ==== verilog/spi_bus_regs.sv ====
// -----------------------------------------------
// stb and cyc must be held until ack, then dropped
// writes ack after one cycle, reads after two
// -----------------------------------------------
module spi_bus_regs (
   input  logic           CLK_I,
   input  logic           RST_I,
   input  spi_pkg::addr_t adr,
   input  spi_pkg::data_t dat_w,
   input  logic           we,
   input  logic           cyc,
   input  logic           stb,
   input  logic           load_take,
   input  logic           frame_start,
   input  logic           frame_done,
   input  logic           busy,
   input  spi_pkg::data_t rx_shift,
   output spi_pkg::data_t dat_r,
   output logic           ack,
   output logic           irq,
   output spi_pkg::data_t tx_data,
   output logic           tx_pending,
   output logic           sso,
   output spi_pkg::ss_t   ss_mask
);
   import spi_pkg::*;

   logic  sel_rx;
   logic  sel_tx;
   logic  sel_stat;
   logic  sel_ctrl;
   logic  sel_mask;
   logic  reg_wr;
   logic  reg_rd;
   logic  read_wait;
   logic  wr_en;
   logic  rd_en;
   data_t wdata_q;
   data_t rx_data;
   logic  trdy;
   logic  toe;
   logic  rrdy;
   logic  roe;
   logic  tmt;
   logic  iroe;
   logic  itoe;
   logic  itrdy;
   logic  irrdy;
   logic  ie;
   data_t status_val;
   data_t control_val;
   data_t mask_val;

   // -----------------------------------------------
   // bus capture and handshake
   // -----------------------------------------------
   always_ff @(posedge CLK_I or posedge RST_I) begin
      if (RST_I) begin
         sel_rx   <= 1'b0;
         sel_tx   <= 1'b0;
         sel_stat <= 1'b0;
         sel_ctrl <= 1'b0;
         sel_mask <= 1'b0;
         reg_wr   <= 1'b0;
         reg_rd   <= 1'b0;
      end else begin
         sel_rx   <= (adr == RX_DATA);
         sel_tx   <= (adr == TX_DATA);
         sel_stat <= (adr == STATUS);
         sel_ctrl <= (adr == CONTROL);
         sel_mask <= (adr == SS_MASK);
         reg_wr   <= we & stb & cyc;
         reg_rd   <= ~we & stb & cyc;
      end
   end

   always_ff @(posedge CLK_I) begin
      wdata_q <= dat_w;
   end

   // reads spend one extra cycle so dat_r is ready with ack
   always_ff @(posedge CLK_I or posedge RST_I) begin
      if (RST_I) begin
         ack       <= 1'b0;
         read_wait <= 1'b0;
      end else if (ack) begin
         ack       <= 1'b0;
         read_wait <= 1'b0;
      end else begin
         if (stb && cyc && (we || read_wait))
            ack <= 1'b1;
         if (stb && cyc && !we)
            read_wait <= 1'b1;
      end
   end

   assign wr_en = reg_wr & ack;   // one update per access
   assign rd_en = reg_rd & ack;

   // -----------------------------------------------
   // registers
   // -----------------------------------------------
   always_ff @(posedge CLK_I or posedge RST_I) begin
      if (RST_I) begin
         tx_data    <= '0;
         tx_pending <= 1'b0;
         rx_data    <= '0;
         ss_mask    <= '0;
      end else begin
         if (wr_en && sel_tx)
            tx_data <= wdata_q;   // overwrites even when trdy is low
         if (wr_en && sel_tx)
            tx_pending <= 1'b1;
         else if (load_take)
            tx_pending <= 1'b0;
         if (frame_done && !rrdy)
            rx_data <= rx_shift;   // old byte kept on overrun
         if (wr_en && sel_mask)
            ss_mask <= wdata_q[SLAVE_NUMBER-1:0];
      end
   end

   always_ff @(posedge CLK_I or posedge RST_I) begin
      if (RST_I) begin
         iroe  <= 1'b0;
         itoe  <= 1'b0;
         itrdy <= 1'b0;
         irrdy <= 1'b0;
         ie    <= 1'b0;
         sso   <= 1'b0;
      end else if (wr_en && sel_ctrl) begin
         iroe  <= wdata_q[CTRL_IROE];
         itoe  <= wdata_q[CTRL_ITOE];
         itrdy <= wdata_q[CTRL_ITRDY];
         irrdy <= wdata_q[CTRL_IRRDY];
         ie    <= wdata_q[CTRL_IE];
         sso   <= wdata_q[CTRL_SSO];
      end
   end

   // status flags
   always_ff @(posedge CLK_I or posedge RST_I) begin
      if (RST_I) begin
         trdy <= 1'b1;
         toe  <= 1'b0;
         rrdy <= 1'b0;
         roe  <= 1'b0;
      end else begin
         if (frame_start)
            trdy <= 1'b1;   // byte moved into the shifter
         else if (wr_en && sel_tx)
            trdy <= 1'b0;
         if (wr_en && sel_tx && !trdy)
            toe <= 1'b1;
         else if (wr_en && sel_stat)
            toe <= 1'b0;
         if (frame_done) begin
            if (rrdy)
               roe <= 1'b1;
            else
               rrdy <= 1'b1;
         end else if (rd_en && sel_rx) begin
            rrdy <= 1'b0;
            roe  <= 1'b0;
         end
      end
   end

   assign tmt = ~(busy | tx_pending);

   always_comb begin
      status_val                = '0;
      status_val[STAT_ERR]      = toe | roe;
      status_val[STAT_RRDY]     = rrdy;
      status_val[STAT_TRDY]     = trdy;
      status_val[STAT_TMT]      = tmt;
      status_val[STAT_TOE]      = toe;
      status_val[STAT_ROE]      = roe;
      control_val               = '0;
      control_val[CTRL_IROE]    = iroe;
      control_val[CTRL_ITOE]    = itoe;
      control_val[CTRL_ITRDY]   = itrdy;
      control_val[CTRL_IRRDY]   = irrdy;
      control_val[CTRL_IE]      = ie;
      control_val[CTRL_SSO]     = sso;
   end

   assign mask_val = {{(DATA_LENGTH-SLAVE_NUMBER){1'b0}}, ss_mask};

   // read mux, loaded once per read
   always_ff @(posedge CLK_I) begin
      if (reg_rd && !ack) begin
         if (sel_rx)
            dat_r <= rx_data;
         else if (sel_tx)
            dat_r <= tx_data;
         else if (sel_stat)
            dat_r <= status_val;
         else if (sel_ctrl)
            dat_r <= control_val;
         else if (sel_mask)
            dat_r <= mask_val;
         else
            dat_r <= '0;
      end
   end

   assign irq = (ie & ((iroe & roe) | (itoe & toe))) |
                (itrdy & trdy) |
                (irrdy & rrdy);

endmodule

// ==== verilog/spi_master.sv ====
// -----------------------------------------------
// spi master with 8 bit register bus, mode 0 only
// -----------------------------------------------
module spi_master (
   input  logic           CLK_I,
   input  logic           RST_I,
   // register bus
   input  spi_pkg::addr_t adr,
   input  spi_pkg::data_t dat_w,
   input  logic           we,
   input  logic           cyc,
   input  logic           stb,
   output spi_pkg::data_t dat_r,
   output logic           ack,
   output logic           irq,
   // spi
   output logic           sclk,
   output logic           mosi,
   input  logic           miso,
   output spi_pkg::ss_t   ss_n
);
   import spi_pkg::*;

   logic  tx_pending;
   logic  sso;
   ss_t   ss_mask;
   logic  load_take;
   logic  frame_start;
   logic  frame_done;
   logic  busy;
   logic  sample;
   logic  shift;
   data_t tx_data;
   data_t rx_shift;

   spi_bus_regs i_spi_bus_regs (
      .CLK_I       (CLK_I),
      .RST_I       (RST_I),
      .adr         (adr),
      .dat_w       (dat_w),
      .we          (we),
      .cyc         (cyc),
      .stb         (stb),
      .load_take   (load_take),
      .frame_start (frame_start),
      .frame_done  (frame_done),
      .busy        (busy),
      .rx_shift    (rx_shift),
      .dat_r       (dat_r),
      .ack         (ack),
      .irq         (irq),
      .tx_data     (tx_data),
      .tx_pending  (tx_pending),
      .sso         (sso),
      .ss_mask     (ss_mask)
   );

   spi_sequencer i_spi_sequencer (
      .CLK_I       (CLK_I),
      .RST_I       (RST_I),
      .tx_pending  (tx_pending),
      .sso         (sso),
      .ss_mask     (ss_mask),
      .load_take   (load_take),
      .frame_start (frame_start),
      .frame_done  (frame_done),
      .busy        (busy),
      .sample      (sample),
      .shift       (shift),
      .sclk        (sclk),
      .ss_n        (ss_n)
   );

   spi_shifter i_spi_shifter (
      .CLK_I       (CLK_I),
      .RST_I       (RST_I),
      .frame_start (frame_start),
      .sample      (sample),
      .shift       (shift),
      .tx_data     (tx_data),
      .miso        (miso),
      .mosi        (mosi),
      .rx_shift    (rx_shift)
   );

endmodule

// ==== verilog/spi_pkg.sv ====
// -----------------------------------------------
// fixed mode 0 master, msb first, 8 bit bus
// SLAVE_NUMBER must not exceed DATA_LENGTH
// -----------------------------------------------
package spi_pkg;

   localparam int DATA_LENGTH     = 8;
   localparam int SLAVE_NUMBER    = 4;
   localparam int CLOCK_SEL       = 1;   // sclk = clk / (2 * (CLOCK_SEL + 1))
   localparam int DELAY_TIME      = 2;   // half-periods before first bit
   localparam int INTERVAL_LENGTH = 2;   // idle half-periods after frame, plus one
   localparam int CNT_WIDTH       = 5;

   typedef logic [DATA_LENGTH-1:0]  data_t;
   typedef logic [SLAVE_NUMBER-1:0] ss_t;
   typedef logic [7:0]              addr_t;

   // register map
   typedef enum logic [7:0] {
      RX_DATA = 8'h00,
      TX_DATA = 8'h04,
      STATUS  = 8'h08,
      CONTROL = 8'h0C,
      SS_MASK = 8'h10
   } reg_addr_e;

   typedef enum logic [2:0] {
      IDLE       = 3'd0,
      LOAD       = 3'd1,
      WAIT       = 3'd2,
      TRANS      = 3'd3,
      TURNAROUND = 3'd4,
      INTERVAL   = 3'd5
   } seq_state_e;

   // status bits, 1:0 read zero
   localparam int STAT_ERR  = 7;
   localparam int STAT_RRDY = 6;
   localparam int STAT_TRDY = 5;
   localparam int STAT_TMT  = 4;
   localparam int STAT_TOE  = 3;
   localparam int STAT_ROE  = 2;

   // control bits, 2 and 6 read zero
   localparam int CTRL_IROE  = 0;
   localparam int CTRL_ITOE  = 1;
   localparam int CTRL_ITRDY = 3;
   localparam int CTRL_IRRDY = 4;
   localparam int CTRL_IE    = 5;
   localparam int CTRL_SSO   = 7;

endpackage

// ==== verilog/spi_sequencer.sv ====
// -----------------------------------------------
// mode 0 frame timing, one byte per frame
// ss_n follows ss_mask when sso is set
// -----------------------------------------------
module spi_sequencer (
   input  logic         CLK_I,
   input  logic         RST_I,
   input  logic         tx_pending,
   input  logic         sso,
   input  spi_pkg::ss_t ss_mask,
   output logic         load_take,
   output logic         frame_start,
   output logic         frame_done,
   output logic         busy,
   output logic         sample,
   output logic         shift,
   output logic         sclk,
   output spi_pkg::ss_t ss_n
);
   import spi_pkg::*;

   seq_state_e           state;
   seq_state_e           next_state;
   logic [CNT_WIDTH-1:0] clk_cnt;    // divider
   logic [CNT_WIDTH-1:0] bit_cnt;    // half-periods or bits, per state
   logic                 tick;
   logic                 select_on;

   assign tick = (clk_cnt == CNT_WIDTH'(CLOCK_SEL));

   // -----------------------------------------------
   // FSM
   // -----------------------------------------------
   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (tx_pending)
               next_state = LOAD;
         end
         LOAD: begin
            next_state = WAIT;
         end
         WAIT: begin
            if (tick && (bit_cnt == CNT_WIDTH'(DELAY_TIME - 1)))
               next_state = TRANS;
         end
         TRANS: begin
            // last falling edge of the byte
            if (tick && sclk && (bit_cnt == CNT_WIDTH'(DATA_LENGTH - 1)))
               next_state = TURNAROUND;
         end
         TURNAROUND: begin
            if (tick)
               next_state = INTERVAL;
         end
         INTERVAL: begin
            if (tick && (bit_cnt == CNT_WIDTH'(INTERVAL_LENGTH)))
               next_state = IDLE;
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   always_ff @(posedge CLK_I or posedge RST_I) begin
      if (RST_I)
         state <= IDLE;
      else
         state <= next_state;
   end

   // -----------------------------------------------
   // counters
   // -----------------------------------------------
   always_ff @(posedge CLK_I or posedge RST_I) begin
      if (RST_I)
         clk_cnt <= '0;
      else if (tick || (state == LOAD) || (next_state == IDLE))
         clk_cnt <= '0;   // aligned before wait starts
      else
         clk_cnt <= clk_cnt + 1'b1;
   end

   always_ff @(posedge CLK_I or posedge RST_I) begin
      if (RST_I)
         bit_cnt <= '0;
      else if (next_state != state)
         bit_cnt <= '0;
      else if (tick && ((state == WAIT) || (state == INTERVAL) ||
                        ((state == TRANS) && sclk)))
         bit_cnt <= bit_cnt + 1'b1;   // in TRANS counts falling edges
   end

   // -----------------------------------------------
   // spi outputs
   // -----------------------------------------------
   always_ff @(posedge CLK_I or posedge RST_I) begin
      if (RST_I)
         sclk <= 1'b0;
      else if ((state == TRANS) && tick)
         sclk <= ~sclk;
   end

   assign select_on = sso || (next_state == WAIT) || (next_state == TRANS) ||
                      (next_state == TURNAROUND);

   always_ff @(posedge CLK_I or posedge RST_I) begin
      if (RST_I)
         ss_n <= '1;
      else if (select_on)
         ss_n <= ~ss_mask;
      else
         ss_n <= '1;
   end

   assign load_take   = (state == LOAD);
   assign frame_start = (next_state == TRANS) && (state != TRANS);
   assign frame_done  = (state == TURNAROUND) && tick;
   assign busy        = (state != IDLE);
   assign sample      = (state == TRANS) && tick && !sclk;   // sclk about to rise
   assign shift       = (state == TRANS) && tick && sclk;    // sclk about to fall

endmodule

// ==== verilog/spi_shifter.sv ====
// -----------------------------------------------
// msb first both ways, miso sampled at sclk rise
// -----------------------------------------------
module spi_shifter (
   input  logic           CLK_I,
   input  logic           RST_I,
   input  logic           frame_start,
   input  logic           sample,
   input  logic           shift,
   input  spi_pkg::data_t tx_data,
   input  logic           miso,
   output logic           mosi,
   output spi_pkg::data_t rx_shift
);
   import spi_pkg::*;

   data_t tx_shift;   // bits still to send, msb aligned

   // mosi changes with the falling edge of sclk
   always_ff @(posedge CLK_I or posedge RST_I) begin
      if (RST_I)
         mosi <= 1'b0;
      else if (frame_start)
         mosi <= tx_data[DATA_LENGTH-1];
      else if (shift)
         mosi <= tx_shift[DATA_LENGTH-1];
   end

   always_ff @(posedge CLK_I) begin
      if (frame_start)
         tx_shift <= {tx_data[DATA_LENGTH-2:0], 1'b0};
      else if (shift)
         tx_shift <= {tx_shift[DATA_LENGTH-2:0], 1'b0};
   end

   // receive fills from the lsb end
   always_ff @(posedge CLK_I) begin
      if (sample)
         rx_shift <= {rx_shift[DATA_LENGTH-2:0], miso};
   end

endmodule
